//--- common/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    typedef logic [$clog2(`NUM_PHYS)-1:0]  phys_tag_t;
    typedef logic [$clog2(`NUM_ARCH)-1:0]  arch_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } unit_sel_t;

endpackage

//--- common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath
`define XLEN 32

// register files
`define NUM_ARCH 32
`define NUM_PHYS 64

// queue sizes
`define ROB_DEPTH 16
`define IQ_DEPTH 8

// multiplier latency in cycles
`define MUL_STAGES 3

`endif

//--- common/isa_pkg.sv
package isa_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one instruction word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } rv_inst_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MUL = 7'b0000001;

endpackage

//--- execute/int_alu.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module int_alu
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alu_issue,
    input  alu_op_t          alu_op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic [`XLEN-1:0] imm,
    input  logic             use_imm,
    input  phys_tag_t        dst,
    input  rob_idx_t         rob,
    output logic             alu_done,
    output phys_tag_t        alu_tag,
    output rob_idx_t         alu_rob,
    output logic [`XLEN-1:0] alu_value
);
    localparam int SH_W = $clog2(`XLEN);

    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] result;
    logic [SH_W-1:0]  shamt;

    assign opb   = use_imm ? imm : b;
    assign shamt = opb[SH_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + opb;
            ALU_SUB:  result = a - opb;
            ALU_AND:  result = a & opb;
            ALU_OR:   result = a | opb;
            ALU_XOR:  result = a ^ opb;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(opb)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, a < opb};
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        alu_tag   <= dst;
        alu_rob   <= rob;
        alu_value <= result;
        if (!rst_n)
            alu_done <= 1'b0;
        else
            alu_done <= alu_issue;
    end

endmodule

//--- execute/mul_pipe.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module mul_pipe
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mul_issue,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  phys_tag_t        dst,
    input  rob_idx_t         rob,
    output logic             mul_done,
    output phys_tag_t        mul_tag,
    output rob_idx_t         mul_rob,
    output logic [`XLEN-1:0] mul_value
);
    logic [`MUL_STAGES-1:0] vld_q;
    phys_tag_t              tag_q  [`MUL_STAGES];
    rob_idx_t               rob_q  [`MUL_STAGES];
    logic [`XLEN-1:0]       prod_q [`MUL_STAGES];

    always_ff @(posedge clk) begin
        prod_q[0] <= a * b;  // low word of the product
        tag_q[0]  <= dst;
        rob_q[0]  <= rob;
        for (int s = 1; s < `MUL_STAGES; s++) begin
            prod_q[s] <= prod_q[s-1];
            tag_q[s]  <= tag_q[s-1];
            rob_q[s]  <= rob_q[s-1];
        end
        if (!rst_n)
            vld_q <= '0;
        else
            vld_q <= {vld_q[`MUL_STAGES-2:0], mul_issue};
    end

    assign mul_done  = vld_q[`MUL_STAGES-1];
    assign mul_tag   = tag_q[`MUL_STAGES-1];
    assign mul_rob   = rob_q[`MUL_STAGES-1];
    assign mul_value = prod_q[`MUL_STAGES-1];

endmodule

//--- files.f
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
rename/rename_unit.sv
issue/issue_queue.sv
source/physical_regfile.sv
execute/int_alu.sv
execute/mul_pipe.sv
retire/reorder_buffer.sv
source/ooo_core_top.sv
verification/tb_ooo_core.sv

//--- issue/issue_queue.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module issue_queue
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             disp_valid,
    input  unit_sel_t        disp_unit,
    input  alu_op_t          disp_op,
    input  phys_tag_t        disp_src1,
    input  phys_tag_t        disp_src2,
    input  logic             disp_src1_ready,
    input  logic             disp_src2_ready,
    input  logic             disp_use_imm,
    input  logic [`XLEN-1:0] disp_imm,
    input  phys_tag_t        disp_dst,
    input  rob_idx_t         disp_rob,
    input  logic             alu_done,
    input  phys_tag_t        alu_tag,
    input  logic             mul_done,
    input  phys_tag_t        mul_tag,
    output logic             iq_full,
    output logic             alu_issue,
    output alu_op_t          alu_op,
    output logic [`XLEN-1:0] alu_imm,
    output logic             alu_use_imm,
    output phys_tag_t        alu_dst,
    output rob_idx_t         alu_rob,
    output logic             mul_issue,
    output phys_tag_t        mul_dst,
    output rob_idx_t         mul_rob,
    output phys_tag_t        rd_tag_a1,
    output phys_tag_t        rd_tag_a2,
    output phys_tag_t        rd_tag_m1,
    output phys_tag_t        rd_tag_m2
);
    localparam int IDX_W = $clog2(`IQ_DEPTH);

    logic [`IQ_DEPTH-1:0] valid_q;
    logic [`IQ_DEPTH-1:0] r1_q;
    logic [`IQ_DEPTH-1:0] r2_q;
    logic [`IQ_DEPTH-1:0] use_imm_q;
    unit_sel_t            unit_q  [`IQ_DEPTH];
    alu_op_t              op_q    [`IQ_DEPTH];
    phys_tag_t            s1_q    [`IQ_DEPTH];
    phys_tag_t            s2_q    [`IQ_DEPTH];
    phys_tag_t            dst_q   [`IQ_DEPTH];
    rob_idx_t             rob_q   [`IQ_DEPTH];
    logic [`XLEN-1:0]     imm_q   [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] older_q [`IQ_DEPTH];  // bit j set when slot j holds an older entry

    logic [`IQ_DEPTH-1:0] cand_a;
    logic [`IQ_DEPTH-1:0] cand_m;
    logic [`IQ_DEPTH-1:0] sel_a;
    logic [`IQ_DEPTH-1:0] sel_m;
    logic [IDX_W-1:0]     a_idx;
    logic [IDX_W-1:0]     m_idx;
    logic [IDX_W-1:0]     ins_idx;
    logic [IDX_W:0]       count;

    function automatic logic woken(input phys_tag_t tag);
        return (alu_done && alu_tag == tag) || (mul_done && mul_tag == tag);
    endfunction

    always_comb begin
        count   = '0;
        ins_idx = '0;
        a_idx   = '0;
        m_idx   = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            cand_a[i] = valid_q[i] && r1_q[i] && r2_q[i] && unit_q[i] == UNIT_ALU;
            cand_m[i] = valid_q[i] && r1_q[i] && r2_q[i] && unit_q[i] == UNIT_MUL;
            if (!valid_q[i])
                ins_idx = IDX_W'(i);  // lowest free slot
        end
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            // oldest ready has no older candidate for the same unit
            sel_a[i] = cand_a[i] && !(|(older_q[i] & cand_a));
            sel_m[i] = cand_m[i] && !(|(older_q[i] & cand_m));
            if (sel_a[i])
                a_idx = IDX_W'(i);
            if (sel_m[i])
                m_idx = IDX_W'(i);
            count = count + valid_q[i];
        end
    end

    // counts the dispatch already in flight
    assign iq_full     = (count + (IDX_W+1)'(disp_valid)) >= `IQ_DEPTH;
    assign alu_issue   = |sel_a;
    assign alu_op      = op_q[a_idx];
    assign alu_imm     = imm_q[a_idx];
    assign alu_use_imm = use_imm_q[a_idx];
    assign alu_dst     = dst_q[a_idx];
    assign alu_rob     = rob_q[a_idx];
    assign rd_tag_a1   = s1_q[a_idx];
    assign rd_tag_a2   = s2_q[a_idx];
    assign mul_issue   = |sel_m;
    assign mul_dst     = dst_q[m_idx];
    assign mul_rob     = rob_q[m_idx];
    assign rd_tag_m1   = s1_q[m_idx];
    assign rd_tag_m2   = s2_q[m_idx];

    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (woken(s1_q[i]))
                r1_q[i] <= 1'b1;
            if (woken(s2_q[i]))
                r2_q[i] <= 1'b1;
        end
        if (disp_valid) begin
            unit_q[ins_idx]    <= disp_unit;
            op_q[ins_idx]      <= disp_op;
            s1_q[ins_idx]      <= disp_src1;
            s2_q[ins_idx]      <= disp_src2;
            r1_q[ins_idx]      <= disp_src1_ready || woken(disp_src1);
            r2_q[ins_idx]      <= disp_src2_ready || woken(disp_src2);
            use_imm_q[ins_idx] <= disp_use_imm;
            imm_q[ins_idx]     <= disp_imm;
            dst_q[ins_idx]     <= disp_dst;
            rob_q[ins_idx]     <= disp_rob;
            for (int i = 0; i < `IQ_DEPTH; i++)
                older_q[i][ins_idx] <= 1'b0;  // newest entry
            older_q[ins_idx] <= valid_q & ~(sel_a | sel_m);
        end
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~(sel_a | sel_m))
                     | ({{(`IQ_DEPTH-1){1'b0}}, disp_valid} << ins_idx);
        end
    end

endmodule

//--- rename/rename_unit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module rename_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  rv_inst_u         inst,
    input  logic             release_valid,
    input  phys_tag_t        release_tag,
    input  logic             iq_full,
    input  logic             rob_full,
    input  logic             src1_ready,
    input  logic             src2_ready,
    output logic             issue_stall,
    output phys_tag_t        src1_tag,
    output phys_tag_t        src2_tag,
    output logic             disp_valid,
    output unit_sel_t        disp_unit,
    output alu_op_t          disp_op,
    output phys_tag_t        disp_src1,
    output phys_tag_t        disp_src2,
    output logic             disp_src1_ready,
    output logic             disp_src2_ready,
    output logic             disp_use_imm,
    output logic [`XLEN-1:0] disp_imm,
    output phys_tag_t        disp_dst,
    output rob_idx_t         disp_rob,
    output logic             rob_alloc,
    output arch_reg_t        rob_rd,
    output logic             rob_we,
    output phys_tag_t        rob_old_tag
);
    localparam int FL_DEPTH = `NUM_PHYS - `NUM_ARCH;
    localparam int FL_W     = $clog2(FL_DEPTH);

    phys_tag_t       rat       [`NUM_ARCH];
    phys_tag_t       free_list [FL_DEPTH];
    logic [FL_W-1:0] fl_head;
    logic [FL_W-1:0] fl_tail;
    logic [FL_W:0]   fl_count;
    rob_idx_t        rob_tail;

    logic      legal;
    logic      use_rs2;
    logic      use_imm;
    logic      we;
    logic      accept;
    unit_sel_t unit;
    alu_op_t   op;

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_t res;
        res = ALU_ADD;
        case (f3)
            F3_ADD:  res = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  res = ALU_SLL;
            F3_SLT:  res = ALU_SLT;
            F3_SLTU: res = ALU_SLTU;
            F3_XOR:  res = ALU_XOR;
            F3_SR:   res = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   res = ALU_OR;
            F3_AND:  res = ALU_AND;
        endcase
        return res;
    endfunction

    always_comb begin
        legal   = 1'b0;
        use_rs2 = 1'b0;
        unit    = UNIT_ALU;
        op      = ALU_ADD;
        case (inst.r.opcode)
            OPC_OP: begin
                if (inst.r.funct7 != F7_MUL) begin
                    legal   = 1'b1;
                    use_rs2 = 1'b1;
                    op      = alu_decode(inst.r.funct3, inst.r.funct7 == F7_ALT);
                end else if (inst.r.funct3 == F3_ADD) begin  // mul, low word only
                    legal   = 1'b1;
                    use_rs2 = 1'b1;
                    unit    = UNIT_MUL;
                end
            end
            OPC_OP_IMM: begin
                legal = 1'b1;
                // srai keeps its alt bit in the upper immediate
                op    = alu_decode(inst.i.funct3,
                                   inst.i.funct3 == F3_SR && inst.r.funct7 == F7_ALT);
            end
            default: ;
        endcase
    end

    // anything unsupported runs as add of x0, x0 with no write
    assign use_imm     = legal && !use_rs2;
    assign we          = legal && inst.r.rd != '0;
    assign src1_tag    = legal ? rat[inst.r.rs1] : '0;
    assign src2_tag    = use_rs2 ? rat[inst.r.rs2] : '0;
    assign issue_stall = (fl_count == '0) || iq_full || rob_full;
    assign accept      = inst_valid && !issue_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_ARCH; r++)
                rat[r] <= phys_tag_t'(r);
            for (int f = 0; f < FL_DEPTH; f++)
                free_list[f] <= phys_tag_t'(`NUM_ARCH + f);
            fl_head    <= '0;
            fl_tail    <= '0;
            fl_count   <= (FL_W+1)'(FL_DEPTH);
            rob_tail   <= '0;
            disp_valid <= 1'b0;
            rob_alloc  <= 1'b0;
            rob_we     <= 1'b0;
        end else begin
            if (accept && we) begin
                rat[inst.r.rd] <= free_list[fl_head];
                fl_head        <= fl_head + 1'b1;
            end
            if (release_valid) begin
                free_list[fl_tail] <= release_tag;
                fl_tail            <= fl_tail + 1'b1;
            end
            fl_count   <= fl_count + (FL_W+1)'(release_valid) - (FL_W+1)'(accept && we);
            if (accept)
                rob_tail <= rob_tail + 1'b1;
            disp_valid <= accept;
            rob_alloc  <= accept;
            rob_we     <= accept && we;
        end
    end

    always_ff @(posedge clk) begin
        disp_unit       <= unit;
        disp_op         <= op;
        disp_src1       <= src1_tag;
        disp_src2       <= src2_tag;
        disp_src1_ready <= src1_ready;
        disp_src2_ready <= src2_ready;
        disp_use_imm    <= use_imm;
        disp_imm        <= {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
        disp_dst        <= we ? free_list[fl_head] : '0;
        disp_rob        <= rob_tail;
        rob_rd          <= inst.r.rd;
        rob_old_tag     <= rat[inst.r.rd];   // mapping before this write
    end

endmodule

//--- retire/reorder_buffer.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module reorder_buffer
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rob_alloc,
    input  arch_reg_t        rob_rd,
    input  logic             rob_we,
    input  phys_tag_t        rob_old_tag,
    input  logic             alu_done,
    input  rob_idx_t         alu_rob,
    input  logic [`XLEN-1:0] alu_value,
    input  logic             mul_done,
    input  rob_idx_t         mul_rob,
    input  logic [`XLEN-1:0] mul_value,
    output logic             rob_full,
    output logic             commit_valid,
    output arch_reg_t        commit_rd,
    output logic             commit_we,
    output logic [`XLEN-1:0] commit_value,
    output logic             release_valid,
    output phys_tag_t        release_tag
);
    localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

    arch_reg_t             rd_q    [`ROB_DEPTH];
    phys_tag_t             old_q   [`ROB_DEPTH];
    logic [`XLEN-1:0]      value_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] we_q;
    logic [`ROB_DEPTH-1:0] done_q;
    rob_idx_t              head;
    rob_idx_t              tail;
    logic [CNT_W-1:0]      count;

    // allocation arrives one cycle after the stall decision
    assign rob_full      = (count + CNT_W'(rob_alloc)) >= `ROB_DEPTH;
    assign commit_valid  = (count != '0) && done_q[head];
    assign commit_rd     = rd_q[head];
    assign commit_we     = we_q[head];
    assign commit_value  = value_q[head];
    assign release_valid = commit_valid && we_q[head];
    assign release_tag   = old_q[head];

    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            rd_q[tail]  <= rob_rd;
            we_q[tail]  <= rob_we;
            old_q[tail] <= rob_old_tag;
        end
        if (alu_done)
            value_q[alu_rob] <= alu_value;
        if (mul_done)
            value_q[mul_rob] <= mul_value;
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (rob_alloc) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (alu_done)
                done_q[alu_rob] <= 1'b1;
            if (mul_done)
                done_q[mul_rob] <= 1'b1;
            if (commit_valid)
                head <= head + 1'b1;
            count <= count + CNT_W'(rob_alloc) - CNT_W'(commit_valid);
        end
    end

endmodule

//--- source/ooo_core_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module ooo_core_top
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst,
    output logic             issue_stall,
    output logic             commit_valid,
    output arch_reg_t        commit_rd,
    output logic             commit_we,
    output logic [`XLEN-1:0] commit_value
);
    phys_tag_t        src1_tag, src2_tag, release_tag, rob_old_tag;
    logic             src1_ready, src2_ready, release_valid, iq_full, rob_full;
    logic             disp_valid, disp_src1_ready, disp_src2_ready, disp_use_imm;
    unit_sel_t        disp_unit;
    alu_op_t          disp_op, alu_op;
    phys_tag_t        disp_src1, disp_src2, disp_dst;
    rob_idx_t         disp_rob;
    logic [`XLEN-1:0] disp_imm, alu_imm;
    logic             rob_alloc, rob_we, alu_issue, alu_use_imm, mul_issue;
    arch_reg_t        rob_rd;
    phys_tag_t        iq_alu_dst, iq_mul_dst, rd_tag_a1, rd_tag_a2, rd_tag_m1, rd_tag_m2;
    rob_idx_t         iq_alu_rob, iq_mul_rob, alu_rob, mul_rob;
    logic [`XLEN-1:0] rd_data_a1, rd_data_a2, rd_data_m1, rd_data_m2;
    logic             alu_done, mul_done;
    phys_tag_t        alu_tag, mul_tag;
    logic [`XLEN-1:0] alu_value, mul_value;

    // input side
    rename_unit u_rename (
        .clk, .rst_n, .inst_valid, .inst, .release_valid, .release_tag, .iq_full, .rob_full,
        .src1_ready, .src2_ready, .issue_stall, .src1_tag, .src2_tag, .disp_valid,
        .disp_unit, .disp_op, .disp_src1, .disp_src2, .disp_src1_ready, .disp_src2_ready,
        .disp_use_imm, .disp_imm, .disp_dst, .disp_rob, .rob_alloc, .rob_rd, .rob_we,
        .rob_old_tag
    );

    issue_queue u_iq (
        .clk, .rst_n, .disp_valid, .disp_unit, .disp_op, .disp_src1, .disp_src2,
        .disp_src1_ready, .disp_src2_ready, .disp_use_imm, .disp_imm, .disp_dst, .disp_rob,
        .alu_done, .alu_tag, .mul_done, .mul_tag, .iq_full, .alu_issue, .alu_op, .alu_imm,
        .alu_use_imm, .alu_dst(iq_alu_dst), .alu_rob(iq_alu_rob), .mul_issue,
        .mul_dst(iq_mul_dst), .mul_rob(iq_mul_rob), .rd_tag_a1, .rd_tag_a2, .rd_tag_m1,
        .rd_tag_m2
    );

    physical_regfile u_prf (
        .clk, .rst_n, .rd_tag_a1, .rd_tag_a2, .rd_tag_m1, .rd_tag_m2, .src1_tag, .src2_tag,
        .alloc_valid(rob_we), .alloc_tag(disp_dst), .alu_done, .alu_tag, .alu_value,
        .mul_done, .mul_tag, .mul_value, .rd_data_a1, .rd_data_a2, .rd_data_m1,
        .rd_data_m2, .src1_ready, .src2_ready
    );

    int_alu u_alu (
        .clk, .rst_n, .alu_issue, .alu_op, .a(rd_data_a1), .b(rd_data_a2), .imm(alu_imm),
        .use_imm(alu_use_imm), .dst(iq_alu_dst), .rob(iq_alu_rob), .alu_done, .alu_tag,
        .alu_rob, .alu_value
    );

    mul_pipe u_mul (
        .clk, .rst_n, .mul_issue, .a(rd_data_m1), .b(rd_data_m2), .dst(iq_mul_dst),
        .rob(iq_mul_rob), .mul_done, .mul_tag, .mul_rob, .mul_value
    );

    // output side
    reorder_buffer u_rob (
        .clk, .rst_n, .rob_alloc, .rob_rd, .rob_we, .rob_old_tag, .alu_done, .alu_rob,
        .alu_value, .mul_done, .mul_rob, .mul_value, .rob_full, .commit_valid, .commit_rd,
        .commit_we, .commit_value, .release_valid, .release_tag
    );

endmodule

//--- source/physical_regfile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module physical_regfile
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  phys_tag_t        rd_tag_a1,
    input  phys_tag_t        rd_tag_a2,
    input  phys_tag_t        rd_tag_m1,
    input  phys_tag_t        rd_tag_m2,
    input  phys_tag_t        src1_tag,
    input  phys_tag_t        src2_tag,
    input  logic             alloc_valid,
    input  phys_tag_t        alloc_tag,
    input  logic             alu_done,
    input  phys_tag_t        alu_tag,
    input  logic [`XLEN-1:0] alu_value,
    input  logic             mul_done,
    input  phys_tag_t        mul_tag,
    input  logic [`XLEN-1:0] mul_value,
    output logic [`XLEN-1:0] rd_data_a1,
    output logic [`XLEN-1:0] rd_data_a2,
    output logic [`XLEN-1:0] rd_data_m1,
    output logic [`XLEN-1:0] rd_data_m2,
    output logic             src1_ready,
    output logic             src2_ready
);
    logic [`XLEN-1:0]     regs [`NUM_PHYS];
    logic [`NUM_PHYS-1:0] ready_q;

    // bypass both the allocation in flight and this cycle's writebacks
    function automatic logic tag_ready(input phys_tag_t tag);
        return (ready_q[tag] && !(alloc_valid && alloc_tag == tag))
            || (alu_done && alu_tag == tag) || (mul_done && mul_tag == tag);
    endfunction

    always_comb begin
        src1_ready = tag_ready(src1_tag);
        src2_ready = tag_ready(src2_tag);
    end

    assign rd_data_a1 = regs[rd_tag_a1];
    assign rd_data_a2 = regs[rd_tag_a2];
    assign rd_data_m1 = regs[rd_tag_m1];
    assign rd_data_m2 = regs[rd_tag_m2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `NUM_ARCH; p++)
                regs[p] <= '0;  // initial architectural state
            ready_q <= {{(`NUM_PHYS-`NUM_ARCH){1'b0}}, {`NUM_ARCH{1'b1}}};
        end else begin
            if (alloc_valid && alloc_tag != '0)
                ready_q[alloc_tag] <= 1'b0;
            if (alu_done && alu_tag != '0) begin  // tag 0 is x0
                regs[alu_tag]    <= alu_value;
                ready_q[alu_tag] <= 1'b1;
            end
            if (mul_done && mul_tag != '0) begin
                regs[mul_tag]    <= mul_value;
                ready_q[mul_tag] <= 1'b1;
            end
        end
    end

endmodule

//--- verification/tb_ooo_core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_ooo_core
    import isa_pkg::*;
(
);
    localparam int N_SEED  = 31;
    localparam int N_RTYPE = 40;
    localparam int N_IMM   = 40;
    localparam int N_MIX   = 40;
    localparam int N_CHAIN = 30;
    localparam int N_ZERO  = 30;
    localparam int N_TOTAL = N_SEED + N_RTYPE + N_IMM + N_MIX + N_CHAIN + N_ZERO;
    localparam int DRAIN_CYCLES = `ROB_DEPTH * 20;

    logic             clk;
    logic             rst_n;
    logic             inst_valid;
    logic [`XLEN-1:0] inst;
    logic             issue_stall;
    logic             commit_valid;
    logic [4:0]       commit_rd;
    logic             commit_we;
    logic [`XLEN-1:0] commit_value;

    integer           seed = 32'h734179c6;
    logic [`XLEN-1:0] regs_m [32];        // architectural model
    logic [37:0]      exp_q  [$];         // {rd, we, value}
    int               errors   = 0;
    int               checks   = 0;
    int               accepted = 0;
    int               commits  = 0;
    int               tests    = 0;
    logic             stall_seen;

    ooo_core_top DUT (
        .clk, .rst_n, .inst_valid, .inst, .issue_stall, .commit_valid, .commit_rd,
        .commit_we, .commit_value
    );

    always #10 clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] r_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        rv_inst_u u;
        u.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return u;
    endfunction

    function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        rv_inst_u u;
        u.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
        return u;
    endfunction

    // reference semantics of the RV32 integer ops
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'b0, a < b};
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? $unsigned(sa >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_exec(input logic [31:0] word);
        rv_inst_u   u;
        logic       we;
        logic [31:0] val;
        logic [31:0] a;
        u   = word;
        we  = 1'b0;
        val = '0;
        a   = regs_m[u.r.rs1];
        if (u.r.opcode == OPC_OP) begin
            if (u.r.funct7 != F7_MUL) begin
                we  = 1'b1;
                val = alu_ref(u.r.funct3, u.r.funct7 == F7_ALT, a, regs_m[u.r.rs2]);
            end else if (u.r.funct3 == F3_ADD) begin
                we  = 1'b1;
                val = a * regs_m[u.r.rs2];
            end
        end else if (u.r.opcode == OPC_OP_IMM) begin
            we  = 1'b1;
            val = alu_ref(u.i.funct3, u.i.funct3 == F3_SR && u.r.funct7 == F7_ALT, a,
                          {{20{u.i.imm[11]}}, u.i.imm});
        end
        if (u.r.rd == 5'd0)
            we = 1'b0;
        if (we)
            regs_m[u.r.rd] = val;
        exp_q.push_back({u.r.rd, we, val});
    endtask

    // holds the word until the core takes it
    task automatic send(input logic [31:0] word);
        if (rnd(4) == 0) begin
            inst_valid = 1'b0;
            @(negedge clk);
        end
        inst       = word;
        inst_valid = 1'b1;
        while (issue_stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
        model_exec(word);
        accepted++;
        @(negedge clk);
    endtask

    // queue only shrinks here, so sampling on the rising edge is safe
    task automatic drain_commits();
        inst_valid = 1'b0;
        for (int c = 0; c < DRAIN_CYCLES && exp_q.size() != 0; c++)
            @(posedge clk);
        check("outstanding expectations", exp_q.size(), 0);
        repeat (4) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - err_start);
    endtask

    function automatic logic [31:0] rand_rtype(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = rnd(8);
        f7 = ((f3 == F3_ADD || f3 == F3_SR) && rnd(2) == 1) ? F7_ALT : 7'b0;
        return r_inst(f7, rs2, rs1, f3, rd, OPC_OP);
    endfunction

    function automatic logic [31:0] rand_itype(input logic [4:0] rd, input logic [4:0] rs1);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = rnd(8);
        imm = rnd(4096);
        if (f3 == F3_SLL)
            imm = {7'b0, imm[4:0]};
        else if (f3 == F3_SR)
            imm = {(rnd(2) == 1) ? F7_ALT : 7'b0, imm[4:0]};  // srai or srli
        return i_inst(imm, rs1, f3, rd);
    endfunction

    always @(negedge clk) begin
        logic [37:0] e;
        if (rst_n && commit_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a commit came out with no accepted instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                check("commit_rd", commit_rd, e[37:33]);
                check("commit_we", commit_we, e[32]);
                if (e[32])
                    check("commit_value", commit_value, e[31:0]);
            end
            commits++;
        end
    end

    initial begin
        repeat (N_TOTAL * 40) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", N_TOTAL * 40);
        $display("sim failed");
        $finish;
    end

    initial begin
        int         e0;
        logic [4:0] last_rd;
        logic [4:0] prev_rd;
        logic [4:0] rd;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        stall_seen = 1'b0;
        for (int r = 0; r < 32; r++)
            regs_m[r] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        repeat (5) begin
            @(negedge clk);
            check("issue_stall after reset", issue_stall, 1'b0);
            check("commit_valid after reset", commit_valid, 1'b0);
        end
        drain_commits();
        end_test("reset state", e0);

        e0 = errors;
        for (int r = 1; r <= N_SEED; r++)
            send(i_inst(rnd(4096), 5'd0, F3_ADD, r));  // give every register a value
        for (int n = 0; n < N_RTYPE; n++)
            send(rand_rtype(rnd(32), rnd(32), rnd(32)));
        drain_commits();
        end_test("register ALU ops", e0);

        e0 = errors;
        for (int n = 0; n < N_IMM; n++)
            send(rand_itype(rnd(32), rnd(32)));
        drain_commits();
        end_test("immediate ALU ops", e0);

        e0 = errors;
        last_rd = 5'd1;
        prev_rd = 5'd2;
        for (int n = 0; n < N_MIX; n++) begin
            rd = 1 + rnd(31);
            if (rnd(2) == 1)
                send(r_inst(F7_MUL, prev_rd, last_rd, F3_ADD, rd, OPC_OP));
            else if (rnd(2) == 1)
                send(rand_rtype(rd, last_rd, prev_rd));
            else
                send(rand_itype(rd, last_rd));
            prev_rd = last_rd;
            last_rd = rd;
        end
        drain_commits();
        end_test("mul and alu chains", e0);

        e0 = errors;
        stall_seen = 1'b0;
        for (int n = 0; n < N_CHAIN; n++)
            send(r_inst(F7_MUL, 5'd6, 5'd5, F3_ADD, 5'd5, OPC_OP));
        drain_commits();
        check("issue_stall seen during mul chain", stall_seen, 1'b1);
        check("commit count", commits, accepted);
        end_test("dependent mul chain", e0);

        e0 = errors;
        for (int n = 0; n < N_ZERO; n++) begin
            case (rnd(3))
                0: send(rand_rtype(5'd0, rnd(32), rnd(32)));
                1: send({$random(seed)} & 32'hffff_ff80 | {25'b0, 7'b0000011 << (rnd(3) * 2)});
                default: begin
                    if (rnd(2) == 1)
                        send(r_inst(7'b0, rnd(32), 5'd0, F3_ADD, 1 + rnd(31), OPC_OP));
                    else
                        send(i_inst(rnd(4096), 5'd0, F3_OR, 1 + rnd(31)));
                end
            endcase
        end
        drain_commits();
        end_test("x0 and unsupported opcodes", e0);

        $display("%0d tests, %0d accepted, %0d committed, %0d checks, %0d errors",
                 tests, accepted, commits, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
